//--- vlog.f
tlul_intg_pkg.sv
secded_inv_64_57_enc.sv
secded_inv_39_32_enc.sv
secded_inv_39_32_dec.sv
tlul_cmd_intg_gen.sv
tlul_req_stage.sv
tlul_rsp_stage.sv
tlul_intg_host.sv
tb_tlul_intg_host.sv

//--- Makefile
# Verilator flow for the TL-UL host integrity project

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= tb_tlul_intg_host
DUT_TOP   ?= tlul_intg_host
OBJ_DIR   ?= obj_dir
SIM_BIN   ?= sim_tlul_intg_host
VFLAGS    ?= --timing
PASS_MSG  ?= Testbench passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(SIM_BIN)

# The run passes only when the pass message shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_tlul_intg_host.sv
// Self-checking testbench for the TL-UL host integrity top with reference encoders and a watchdog
`timescale 1ns/1ns
`default_nettype none

module tb_tlul_intg_host;

    localparam int NUM_CMD = 24;
    localparam int NUM_RSP = 48;
    localparam int NUM_BURST = 64;
    localparam int NUM_TESTS = NUM_CMD + NUM_RSP + NUM_BURST;
    // Budget of two clock periods per test plus reset and drain
    localparam int WATCHDOG_NS = (NUM_TESTS + 16 + 20) * 8 * 2;

    logic                       clk_i = 1'b0;
    logic                       reset_i;
    logic                       cmd_valid_i;
    tlul_intg_pkg::tl_cmd_t     cmd_i;
    logic                       a_valid_o;
    tlul_intg_pkg::tl_a_chan_t  a_chan_o;
    logic                       d_valid_i;
    tlul_intg_pkg::tl_rsp_t     d_rsp_i;
    logic                       rsp_valid_o;
    tlul_intg_pkg::rsp_out_t    rsp_o;

    // Expected outputs in strobe order with one queue per path
    tlul_intg_pkg::tl_a_chan_t  exp_a_q[$];
    tlul_intg_pkg::rsp_out_t    exp_rsp_q[$];
    // Cleared for double-bit errors, whose data is not defined
    bit                         exp_chk_q[$];
    logic [31:0]                rand_state = 32'd12424;
    // Strobe levels seen on the previous falling edge
    logic                       cmd_seen = 1'b0;
    logic                       rsp_seen = 1'b0;

    tlul_intg_host i_dut (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .a_valid_o   (a_valid_o),
        .a_chan_o    (a_chan_o),
        .d_valid_i   (d_valid_i),
        .d_rsp_i     (d_rsp_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o)
    );

    always #4 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_next();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    // Inverted 64/57 check bits of the zero-extended 43-bit command
    function automatic logic [6:0] ref_cmd_intg(input tlul_intg_pkg::tl_cmd_t c);
        logic [56:0] payload;
        logic [6:0]  check;
        payload = {14'd0, c.instr_type, c.addr, c.opcode, c.mask};
        for (int k = 0; k < 7; k++) begin
            check[k] = ^(payload & tlul_intg_pkg::SECDED_57_MASKS[k]);
        end
        return check ^ tlul_intg_pkg::SECDED_INV_MASK_7;
    endfunction

    // Inverted 39/32 check bits of one data word
    function automatic logic [6:0] ref_data_intg(input logic [31:0] d);
        logic [6:0] check;
        for (int k = 0; k < 7; k++) begin
            check[k] = ^(d & tlul_intg_pkg::SECDED_32_MASKS[k]);
        end
        return check ^ tlul_intg_pkg::SECDED_INV_MASK_7;
    endfunction

    function automatic tlul_intg_pkg::tl_a_op_e op_from_index(input int idx);
        case (idx)
            0:       return tlul_intg_pkg::PUT_FULL_DATA;
            1:       return tlul_intg_pkg::PUT_PARTIAL_DATA;
            default: return tlul_intg_pkg::GET;
        endcase
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("error %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // Moves to 1 ns after the next rising edge and drops both strobes
    task automatic step_cycle();
        @(posedge clk_i);
        #1;
        cmd_valid_i = 1'b0;
        d_valid_i   = 1'b0;
    endtask

    task automatic put_cmd(input tlul_intg_pkg::tl_a_op_e op, input tlul_intg_pkg::mubi4_t it,
                           input logic [31:0] data);
        tlul_intg_pkg::tl_cmd_t    c;
        tlul_intg_pkg::tl_a_chan_t e;
        logic [31:0]               r;
        r = lcg_next();
        c.instr_type = it;
        c.addr       = lcg_next();
        c.opcode     = op;
        c.mask       = r[31:28];
        c.data       = data;
        e.cmd        = c;
        e.cmd_intg   = ref_cmd_intg(c);
        e.data_intg  = ref_data_intg(data);
        cmd_valid_i  = 1'b1;
        cmd_i        = c;
        exp_a_q.push_back(e);
    endtask

    // Kind 0 is a clean codeword, kind 1 has one flipped bit and kind 2 has two
    task automatic put_random_rsp(input int kind);
        logic [31:0]             d;
        logic [38:0]             cw;
        int                      pos_a;
        int                      pos_b;
        tlul_intg_pkg::rsp_out_t e;
        d     = lcg_next();
        cw    = {ref_data_intg(d), d};
        pos_a = int'(lcg_next() % 32'd39);
        pos_b = (pos_a + 1 + int'(lcg_next() % 32'd38)) % 39;
        if (kind >= 1) begin
            cw[pos_a] = ~cw[pos_a];
        end
        if (kind == 2) begin
            cw[pos_b] = ~cw[pos_b];
        end
        e.data            = d;
        e.err_corr        = (kind == 1);
        e.err_uncorr      = (kind == 2);
        d_valid_i         = 1'b1;
        d_rsp_i.data      = cw[31:0];
        d_rsp_i.data_intg = cw[38:32];
        exp_rsp_q.push_back(e);
        exp_chk_q.push_back(kind != 2);
    endtask

    task automatic compare_a_chan();
        tlul_intg_pkg::tl_a_chan_t e;
        if (exp_a_q.size() == 0) begin
            fail_run("An A-channel word came out with no command outstanding");
        end else begin
            e = exp_a_q.pop_front();
            check_value("a_chan_o.cmd.instr_type", 64'(a_chan_o.cmd.instr_type),
                        64'(e.cmd.instr_type));
            check_value("a_chan_o.cmd.addr", 64'(a_chan_o.cmd.addr), 64'(e.cmd.addr));
            check_value("a_chan_o.cmd.opcode", 64'(a_chan_o.cmd.opcode), 64'(e.cmd.opcode));
            check_value("a_chan_o.cmd.mask", 64'(a_chan_o.cmd.mask), 64'(e.cmd.mask));
            check_value("a_chan_o.cmd.data", 64'(a_chan_o.cmd.data), 64'(e.cmd.data));
            check_value("a_chan_o.cmd_intg", 64'(a_chan_o.cmd_intg), 64'(e.cmd_intg));
            check_value("a_chan_o.data_intg", 64'(a_chan_o.data_intg), 64'(e.data_intg));
        end
    endtask

    task automatic compare_rsp();
        tlul_intg_pkg::rsp_out_t e;
        bit                      chk;
        if (exp_rsp_q.size() == 0) begin
            fail_run("A response result came out with no response outstanding");
        end else begin
            e   = exp_rsp_q.pop_front();
            chk = exp_chk_q.pop_front();
            if (chk) begin
                check_value("rsp_o.data", 64'(rsp_o.data), 64'(e.data));
            end
            check_value("rsp_o.err_corr", 64'(rsp_o.err_corr), 64'(e.err_corr));
            check_value("rsp_o.err_uncorr", 64'(rsp_o.err_uncorr), 64'(e.err_uncorr));
        end
    endtask

    // Outputs are stable at the falling edge, so each valid must mirror the strobe
    // that was on its input one edge earlier
    always @(negedge clk_i) begin
        check_value("a_valid_o", 64'(a_valid_o), 64'(cmd_seen));
        check_value("rsp_valid_o", 64'(rsp_valid_o), 64'(rsp_seen));
        cmd_seen = cmd_valid_i;
        rsp_seen = d_valid_i;
        if (a_valid_o) begin
            compare_a_chan();
        end
        if (rsp_valid_o) begin
            compare_rsp();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run("Timeout, the run did not finish in the expected time");
    end

    initial begin
        logic [31:0] r;
        logic [31:0] data;
        reset_i     = 1'b1;
        cmd_valid_i = 1'b0;
        cmd_i       = '0;
        d_valid_i   = 1'b0;
        d_rsp_i     = '0;
        repeat (16) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        // A few quiet cycles, during which both valids must stay low
        repeat (4) step_cycle();

        // Every opcode with both instruction types and with all-zero and all-one data
        for (int o = 0; o < 3; o++) begin
            for (int m = 0; m < 2; m++) begin
                for (int v = 0; v < 4; v++) begin
                    case (v)
                        0:       data = 32'h0000_0000;
                        1:       data = 32'hFFFF_FFFF;
                        default: data = lcg_next();
                    endcase
                    step_cycle();
                    put_cmd(op_from_index(o),
                            (m == 1) ? tlul_intg_pkg::MUBI4_TRUE : tlul_intg_pkg::MUBI4_FALSE,
                            data);
                    step_cycle();
                end
            end
        end

        // Clean, single-error and double-error responses in equal thirds
        for (int i = 0; i < NUM_RSP; i++) begin
            step_cycle();
            put_random_rsp(i % 3);
            step_cycle();
        end

        // Both paths strobed on every cycle
        for (int i = 0; i < NUM_BURST; i++) begin
            step_cycle();
            r = lcg_next();
            put_cmd(op_from_index(int'(lcg_next() % 32'd3)),
                    r[31] ? tlul_intg_pkg::MUBI4_TRUE : tlul_intg_pkg::MUBI4_FALSE,
                    lcg_next());
            put_random_rsp(int'(lcg_next() % 32'd3));
        end
        repeat (3) step_cycle();

        if (exp_a_q.size() != 0 || exp_rsp_q.size() != 0) begin
            fail_run("Some strobes never produced an output");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tlul_intg_host.sv
// TL-UL host integrity top that joins the request and response stages
`timescale 1ns/1ns
`default_nettype none

module tlul_intg_host (
    input  wire logic                        clk_i,
    input  wire logic                        reset_i,
    // Command side
    input  wire logic                        cmd_valid_i,
    input  wire tlul_intg_pkg::tl_cmd_t      cmd_i,
    output logic                             a_valid_o,
    output tlul_intg_pkg::tl_a_chan_t        a_chan_o,
    // Response side
    input  wire logic                        d_valid_i,
    input  wire tlul_intg_pkg::tl_rsp_t      d_rsp_i,
    output logic                             rsp_valid_o,
    output tlul_intg_pkg::rsp_out_t          rsp_o
);

    // Command path with one register between strobe and A-channel word
    tlul_req_stage i_req_stage (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .a_valid_o   (a_valid_o),
        .a_chan_o    (a_chan_o)
    );

    // Response path runs on its own, so both directions can be busy in the same cycle
    tlul_rsp_stage i_rsp_stage (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .d_valid_i   (d_valid_i),
        .d_rsp_i     (d_rsp_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o)
    );

endmodule

`default_nettype wire

//--- tlul_rsp_stage.sv
// TL-UL response stage that checks read data integrity and registers the corrected result
`timescale 1ns/1ns
`default_nettype none

module tlul_rsp_stage (
    input  wire logic                        clk_i,
    input  wire logic                        reset_i,
    input  wire logic                        d_valid_i,
    input  wire tlul_intg_pkg::tl_rsp_t      d_rsp_i,
    output logic                             rsp_valid_o,
    output tlul_intg_pkg::rsp_out_t          rsp_o
);

    // Decoder outputs for the word on the input this cycle
    logic [tlul_intg_pkg::DATA_MAX_W-1:0] dec_data;
    logic [1:0]                           dec_err;
    tlul_intg_pkg::rsp_out_t              rsp_d;
    tlul_intg_pkg::rsp_out_t              rsp_q;
    logic                                 rsp_valid_q;

    // The codeword places the integrity bits above the data, as the encoder does
    secded_inv_39_32_dec i_data_dec (
        .data_i     ({d_rsp_i.data_intg, d_rsp_i.data}),
        .data_o     (dec_data),
        .syndrome_o (),
        .err_o      (dec_err)
    );

    // Decoding happens ahead of the register so the result lands one cycle later
    always_comb begin
        rsp_d.data       = dec_data;
        rsp_d.err_corr   = dec_err[0];
        rsp_d.err_uncorr = dec_err[1];
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= d_valid_i;
        end
    end

    // Result is captured only when a response arrives
    always_ff @(posedge clk_i) begin
        if (d_valid_i) begin
            rsp_q <= rsp_d;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

//--- tlul_req_stage.sv
// TL-UL request stage that registers a command with its integrity codes into an A-channel word
`timescale 1ns/1ns
`default_nettype none

module tlul_req_stage (
    input  wire logic                        clk_i,
    input  wire logic                        reset_i,
    input  wire logic                        cmd_valid_i,
    input  wire tlul_intg_pkg::tl_cmd_t      cmd_i,
    output logic                             a_valid_o,
    output tlul_intg_pkg::tl_a_chan_t        a_chan_o
);

    // A-channel word assembled in the same cycle as the strobe
    tlul_intg_pkg::tl_a_chan_t a_chan_d;
    tlul_intg_pkg::tl_a_chan_t a_chan_q;
    logic                      a_valid_q;

    // Integrity is computed on the incoming fields before the register
    tlul_cmd_intg_gen #(
        .EnableDataIntgGen (tlul_intg_pkg::ENABLE_DATA_INTG_GEN)
    ) i_cmd_intg_gen (
        .instr_type_i (cmd_i.instr_type),
        .addr_i       (cmd_i.addr),
        .opcode_i     (cmd_i.opcode),
        .mask_i       (cmd_i.mask),
        .data_i       (cmd_i.data),
        .cmd_intg_o   (a_chan_d.cmd_intg),
        .data_intg_o  (a_chan_d.data_intg)
    );

    // The command fields travel unchanged next to their codes
    assign a_chan_d.cmd = cmd_i;

    // Valid follows the strobe with one cycle of delay
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            a_valid_q <= 1'b0;
        end else begin
            a_valid_q <= cmd_valid_i;
        end
    end

    // Payload is only loaded on a strobe and holds until the next one
    always_ff @(posedge clk_i) begin
        if (cmd_valid_i) begin
            a_chan_q <= a_chan_d;
        end
    end

    assign a_valid_o = a_valid_q;
    assign a_chan_o  = a_chan_q;

endmodule

`default_nettype wire

//--- tlul_cmd_intg_gen.sv
// TL-UL command integrity generator that builds the command and data integrity codes
`timescale 1ns/1ns
`default_nettype none

module tlul_cmd_intg_gen #(
    parameter bit EnableDataIntgGen = 1'b1
) (
    input  wire tlul_intg_pkg::mubi4_t                      instr_type_i,
    input  wire logic [tlul_intg_pkg::TL_AW-1:0]            addr_i,
    input  wire tlul_intg_pkg::tl_a_op_e                    opcode_i,
    input  wire logic [tlul_intg_pkg::TL_DBW-1:0]           mask_i,
    input  wire logic [tlul_intg_pkg::TL_DW-1:0]            data_i,
    output logic [tlul_intg_pkg::H2D_CMD_INTG_W-1:0]        cmd_intg_o,
    output logic [tlul_intg_pkg::DATA_INTG_W-1:0]           data_intg_o
);

    // Command fields in the order the integrity code covers them
    tlul_intg_pkg::tl_h2d_cmd_intg_t cmd;
    // Full 64-bit codeword of which only the check bits leave this block
    logic [tlul_intg_pkg::H2D_CMD_MAX_W+tlul_intg_pkg::H2D_CMD_INTG_W-1:0] cmd_code;

    always_comb begin
        cmd.instr_type = instr_type_i;
        cmd.addr       = addr_i;
        cmd.opcode     = opcode_i;
        cmd.mask       = mask_i;
    end

    // The 43-bit command is zero-extended to the 57-bit encoder payload
    secded_inv_64_57_enc i_cmd_enc (
        .data_i ({{(tlul_intg_pkg::H2D_CMD_MAX_W - tlul_intg_pkg::H2D_CMD_W){1'b0}}, cmd}),
        .data_o (cmd_code)
    );

    assign cmd_intg_o = cmd_code[tlul_intg_pkg::H2D_CMD_MAX_W +: tlul_intg_pkg::H2D_CMD_INTG_W];

    if (EnableDataIntgGen) begin : g_data_intg
        // Codeword of the write data
        logic [tlul_intg_pkg::DATA_MAX_W+tlul_intg_pkg::DATA_INTG_W-1:0] data_code;

        secded_inv_39_32_enc i_data_enc (
            .data_i (data_i),
            .data_o (data_code)
        );

        assign data_intg_o = data_code[tlul_intg_pkg::DATA_MAX_W +: tlul_intg_pkg::DATA_INTG_W];
    end else begin : g_no_data_intg
        // Without data integrity the code field is sent as zero
        assign data_intg_o = '0;
    end

endmodule

`default_nettype wire

//--- secded_inv_39_32_dec.sv
// Inverted Hsiao 39/32 SECDED decoder that corrects single-bit and flags double-bit errors
`timescale 1ns/1ns
`default_nettype none

module secded_inv_39_32_dec (
    input  wire logic [tlul_intg_pkg::DATA_MAX_W+tlul_intg_pkg::DATA_INTG_W-1:0] data_i,
    output logic [tlul_intg_pkg::DATA_MAX_W-1:0]                                 data_o,
    output logic [tlul_intg_pkg::DATA_INTG_W-1:0]                                syndrome_o,
    output logic [1:0]                                                           err_o
);

    // Received check bits with the inversion taken off again
    logic [tlul_intg_pkg::DATA_INTG_W-1:0] check_rx;
    // Check bits recomputed from the received data
    logic [tlul_intg_pkg::DATA_INTG_W-1:0] check_calc;

    assign check_rx = data_i[tlul_intg_pkg::DATA_MAX_W +: tlul_intg_pkg::DATA_INTG_W]
                      ^ tlul_intg_pkg::SECDED_INV_MASK_7;

    always_comb begin
        for (int k = 0; k < tlul_intg_pkg::DATA_INTG_W; k++) begin
            check_calc[k] = ^(data_i[tlul_intg_pkg::DATA_MAX_W-1:0]
                              & tlul_intg_pkg::SECDED_32_MASKS[k]);
        end
    end

    // A clean codeword gives an all-zero syndrome
    assign syndrome_o = check_calc ^ check_rx;

    // Every data column of the Hsiao matrix has odd weight, so the syndrome of a
    // single flip equals the column of the flipped bit
    for (genvar i = 0; i < tlul_intg_pkg::DATA_MAX_W; i++) begin : g_correct
        // Column i of the parity matrix, one bit per check bit
        logic [tlul_intg_pkg::DATA_INTG_W-1:0] column;

        for (genvar k = 0; k < tlul_intg_pkg::DATA_INTG_W; k++) begin : g_column
            assign column[k] = tlul_intg_pkg::SECDED_32_MASKS[k][i];
        end

        // Flip the bit whose column matches, which repairs a single data error
        assign data_o[i] = data_i[i] ^ (syndrome_o == column);
    end

    // Odd weight means a single error, which may also sit in a check bit
    assign err_o[0] = ^syndrome_o;
    // Even nonzero weight cannot be repaired
    assign err_o[1] = ~(^syndrome_o) & (|syndrome_o);

endmodule

`default_nettype wire

//--- secded_inv_39_32_enc.sv
// Inverted Hsiao 39/32 SECDED encoder that appends seven check bits to a 32-bit word
`timescale 1ns/1ns
`default_nettype none

module secded_inv_39_32_enc (
    input  wire logic [tlul_intg_pkg::DATA_MAX_W-1:0]                            data_i,
    output logic [tlul_intg_pkg::DATA_MAX_W+tlul_intg_pkg::DATA_INTG_W-1:0]      data_o
);

    // Parity of each check bit before inversion
    logic [tlul_intg_pkg::DATA_INTG_W-1:0] check;

    // Same construction as the command encoder with the 32-bit masks
    always_comb begin
        for (int k = 0; k < tlul_intg_pkg::DATA_INTG_W; k++) begin
            check[k] = ^(data_i & tlul_intg_pkg::SECDED_32_MASKS[k]);
        end
    end

    // Inversion makes the code of an all-zero word nonzero
    assign data_o = {check ^ tlul_intg_pkg::SECDED_INV_MASK_7, data_i};

endmodule

`default_nettype wire

//--- secded_inv_64_57_enc.sv
// Inverted Hsiao 64/57 SECDED encoder that appends seven check bits to a 57-bit payload
`timescale 1ns/1ns
`default_nettype none

module secded_inv_64_57_enc (
    input  wire logic [tlul_intg_pkg::H2D_CMD_MAX_W-1:0]                                data_i,
    output logic [tlul_intg_pkg::H2D_CMD_MAX_W+tlul_intg_pkg::H2D_CMD_INTG_W-1:0]       data_o
);

    // Raw parity of each check bit before the inversion is applied
    logic [tlul_intg_pkg::H2D_CMD_INTG_W-1:0] check;

    // Each check bit covers the payload bits that its mask selects
    always_comb begin
        for (int k = 0; k < tlul_intg_pkg::H2D_CMD_INTG_W; k++) begin
            check[k] = ^(data_i & tlul_intg_pkg::SECDED_57_MASKS[k]);
        end
    end

    // The code is systematic, so the payload passes unchanged into the low bits
    // and the inverted check bits sit on top
    assign data_o = {check ^ tlul_intg_pkg::SECDED_INV_MASK_7, data_i};

endmodule

`default_nettype wire

//--- tlul_intg_pkg.sv
// TL-UL integrity package with bus widths, opcodes, mubi4 values, SECDED masks and bus structs
`default_nettype none

package tlul_intg_pkg;

    // Bus widths of the A-channel and the D-channel
    localparam int unsigned TL_AW = 32;
    localparam int unsigned TL_DW = 32;
    localparam int unsigned TL_DBW = 4;

    // Both integrity codes carry seven check bits
    localparam int unsigned H2D_CMD_INTG_W = 7;
    localparam int unsigned DATA_INTG_W = 7;

    // Payload widths that the two encoders accept
    localparam int unsigned H2D_CMD_MAX_W = 57;
    localparam int unsigned DATA_MAX_W = 32;

    // The data integrity code is attached to every outgoing command
    localparam bit ENABLE_DATA_INTG_GEN = 1'b1;

    // A-channel opcodes that a host can issue
    typedef enum logic [2:0] {
        PUT_FULL_DATA    = 3'h0,
        PUT_PARTIAL_DATA = 3'h1,
        GET              = 3'h4
    } tl_a_op_e;

    // Multi-bit boolean for the instruction type, so a single flip is never a valid value
    typedef logic [3:0] mubi4_t;
    localparam mubi4_t MUBI4_TRUE = 4'h6;
    localparam mubi4_t MUBI4_FALSE = 4'h9;

    // Fields covered by the command integrity code, MSB first
    typedef struct packed {
        mubi4_t             instr_type;
        logic [TL_AW-1:0]   addr;
        tl_a_op_e           opcode;
        logic [TL_DBW-1:0]  mask;
    } tl_h2d_cmd_intg_t;

    // The command struct is 43 bits wide and is zero-extended up to H2D_CMD_MAX_W
    localparam int unsigned H2D_CMD_W = $bits(tl_h2d_cmd_intg_t);

    // Hsiao masks of the 64/57 code, listed from check bit 6 down to check bit 0
    localparam logic [6:0][H2D_CMD_MAX_W-1:0] SECDED_57_MASKS = {
        57'h1FBDDA769A46910,
        57'h1F7BB56D5525488,
        57'h1EF76CDB2C93244,
        57'h1DEEE3B8E388E22,
        57'h1BDE1F87E0781E1,
        57'h17C1FF801FF801F,
        57'h103FFF800007FFF
    };

    // Hsiao masks of the 39/32 code, again from check bit 6 down to check bit 0
    localparam logic [6:0][DATA_MAX_W-1:0] SECDED_32_MASKS = {
        32'h98505586,
        32'h2DCC624C,
        32'hC2C1323B,
        32'h31234ED1,
        32'h413D89AA,
        32'hDEBA8050,
        32'h2606BD25
    };

    // Inverting these check bits keeps an all-zero word from being a valid codeword
    localparam logic [6:0] SECDED_INV_MASK_7 = 7'h2A;

    // Command as it arrives from the front end
    typedef struct packed {
        mubi4_t             instr_type;
        logic [TL_AW-1:0]   addr;
        tl_a_op_e           opcode;
        logic [TL_DBW-1:0]  mask;
        logic [TL_DW-1:0]   data;
    } tl_cmd_t;

    // A-channel word with both integrity codes attached
    typedef struct packed {
        tl_cmd_t                    cmd;
        logic [H2D_CMD_INTG_W-1:0]  cmd_intg;
        logic [DATA_INTG_W-1:0]     data_intg;
    } tl_a_chan_t;

    // Response data as received on the D-channel
    typedef struct packed {
        logic [TL_DW-1:0]        data;
        logic [DATA_INTG_W-1:0]  data_intg;
    } tl_rsp_t;

    // Checked response handed back to the front end
    typedef struct packed {
        logic [TL_DW-1:0]  data;
        logic              err_corr;
        logic              err_uncorr;
    } rsp_out_t;

endpackage

`default_nettype wire
